// File: vga_text_top.f
common/vga_text_pkg.sv
video/vga_timing.sv
video/vga_text_ram.sv
video/vga_font_ram.sv
video/vga_pixel_pipe.sv
verilog/vga_bus_regs.sv
verilog/vga_text_top.sv
tb/tb_vga_text_top.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vga_text_top \
    -f vga_text_top.f -o sim_vga_text
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_vga_text > sim.log 2>&1
run_status=$?
cat sim.log

if grep -qF "** PASS **" sim.log; then
    exit 0
fi
echo "simulation failed (status $run_status)"
exit 1

// File: tb/tb_vga_text_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vga_text_top
    import vga_text_pkg::*;
();

    localparam int DRIVE_DLY_NS = 1;                        // inputs move after the edge
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int SETUP_CYCLES = 4 * (FONT_WORDS + 3 * TEXT_WORDS + 64);
    localparam int LIMIT_CYCLES = SETUP_CYCLES + 4 * FRAME_CYCLES;
    localparam int HS_FIRST     = H_ACTIVE + H_FRONT;       // 656
    localparam int VS_FIRST     = V_ACTIVE + V_FRONT;       // 490

    logic       clk_i, rst_n_i;
    logic       wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    wb_adr_t    wb_adr_i;
    logic [3:0] wb_sel_i;
    wb_dat_t    wb_dat_i, wb_dat_o;
    color_t     red_o, green_o, blue_o;
    logic       hsync_o, vsync_o, de_o;

    vga_text_top i_dut (.*);

    // model of what the host has written
    char_code_t  text_model  [N_COLS*N_ROWS];  // one code per tile
    glyph_row_t  font_model  [FONT_WORDS];
    color_t      color_model [COLOR_WORDS];
    logic [31:0] rng;

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;  // 4 ns
    end

    // --------------------------------------------------
    // reference and helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected {r, g, b} of a visible pixel
    function automatic logic [11:0] expected_rgb(input int x, input int y);
        int          tile;
        char_code_t  code;
        glyph_row_t  row;
        logic [11:0] rgb;
        tile = (y / GLYPH_H) * N_COLS + x / GLYPH_W;
        code = text_model[tile];
        row  = font_model[int'(code) * GLYPH_H + y % GLYPH_H];
        if (row[7 - x % GLYPH_W]) begin  // leftmost pixel is bit 7
            rgb = {color_model[1], color_model[3], color_model[5]};
        end else begin
            rgb = {color_model[0], color_model[2], color_model[4]};
        end
        return rgb;
    endfunction

    // bus view of a text word, bit 7 of every byte zero
    function automatic wb_dat_t text_word(input int w);
        wb_dat_t d;
        d = '0;
        for (int l = 0; l < CHARS_PER_WORD; l++) begin
            d[8*l +: 7] = text_model[CHARS_PER_WORD*w + l];
        end
        return d;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_color(input string what, input int x, input int y,
                               input color_t got, input color_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t ns: %s at (%0d,%0d) is %h, expected %h",
                               $time, what, x, y, got, exp));
        end
    endtask

    task automatic check_word(input string what, input wb_dat_t got, input wb_dat_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_count(input string what, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    // --------------------------------------------------
    // wishbone master
    // --------------------------------------------------
    task automatic wait_ack();
        do begin
            @(posedge clk_i);
            #DRIVE_DLY_NS;
        end while (!wb_ack_o);  // ack follows the start cycle
    endtask

    task automatic bus_write(input wb_adr_t adr, input logic [3:0] sel, input wb_dat_t dat);
        @(posedge clk_i);
        #DRIVE_DLY_NS;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_sel_i = sel;
        wb_dat_i = dat;
        wait_ack();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_read(input wb_adr_t adr, output wb_dat_t dat);
        @(posedge clk_i);
        #DRIVE_DLY_NS;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        wb_sel_i = 4'hF;
        wait_ack();
        dat      = wb_dat_o;  // valid while ack is high
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    // six nibbles, register 0 in vals[3:0]
    task automatic write_colors(input logic [23:0] vals);
        wb_dat_t got;
        for (int i = 0; i < COLOR_WORDS; i++) begin
            rng = xorshift32(rng);
            bus_write(wb_adr_t'(COLOR_BASE + i), 4'h0, {rng[31:4], vals[4*i +: 4]});
            color_model[i] = vals[4*i +: 4];
        end
        for (int i = 0; i < COLOR_WORDS; i++) begin
            bus_read(wb_adr_t'(COLOR_BASE + i), got);
            check_word("colour register", got, wb_dat_t'(color_model[i]));
        end
    endtask

    // --------------------------------------------------
    // one frame, starting at the vsync_o rising edge
    // --------------------------------------------------
    task automatic check_frame();
        int          x, y, de_cnt, hs_cnt, de_lines, vs_lines;
        logic [11:0] rgb;
        x        = 0;
        y        = VS_FIRST + V_SYNC;  // outputs show line 492 at the edge
        de_cnt   = 0;
        hs_cnt   = 0;
        de_lines = 0;
        vs_lines = 0;
        @(posedge vsync_o);
        repeat (FRAME_CYCLES) begin
            @(negedge clk_i);  // outputs settled
            check_flag("de_o", de_o, (x < H_ACTIVE) && (y < V_ACTIVE));
            check_flag("hsync_o", hsync_o, !((x >= HS_FIRST) && (x < HS_FIRST + H_SYNC)));
            check_flag("vsync_o", vsync_o, !((y >= VS_FIRST) && (y < VS_FIRST + V_SYNC)));
            rgb = de_o ? expected_rgb(x, y) : 12'h000;  // black outside de
            check_color("red_o", x, y, red_o, rgb[11:8]);
            check_color("green_o", x, y, green_o, rgb[7:4]);
            check_color("blue_o", x, y, blue_o, rgb[3:0]);
            de_cnt += int'(de_o);
            hs_cnt += int'(!hsync_o);
            if (x == H_TOTAL - 1) begin  // end of line
                check_count("hsync_o low cycles", coord_t'(hs_cnt), coord_t'(H_SYNC));
                if (de_cnt != 0) begin
                    check_count("de_o cycles in line", coord_t'(de_cnt), coord_t'(H_ACTIVE));
                    de_lines++;
                end
                vs_lines += int'(!vsync_o);
                de_cnt = 0;
                hs_cnt = 0;
                x      = 0;
                y      = (y == V_TOTAL - 1) ? 0 : y + 1;
            end else begin
                x++;
            end
        end
        check_count("lines with de_o", coord_t'(de_lines), coord_t'(V_ACTIVE));
        check_count("vsync_o low lines", coord_t'(vs_lines), coord_t'(V_SYNC));
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk_i);
        $display("timeout: the tests did not finish within the expected number of cycles");
        $display("** FAIL **");
        $fatal(1);
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        wb_dat_t    got, dat;
        logic [3:0] sel;
        int         w;
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_sel_i = '0;
        wb_dat_i = '0;
        rng      = 32'h11c5_052d;
        color_model = '{4'h0, 4'hF, 4'h0, 4'hF, 4'h0, 4'hF};  // black background, white glyphs
        repeat (5) @(posedge clk_i);
        #DRIVE_DLY_NS;

        // idle outputs in reset
        check_flag("hsync_o in reset", hsync_o, 1'b1);
        check_flag("vsync_o in reset", vsync_o, 1'b1);
        check_flag("de_o in reset", de_o, 1'b0);
        check_flag("wb_ack_o in reset", wb_ack_o, 1'b0);
        check_color("red_o in reset", 0, 0, red_o, 4'h0);
        check_color("green_o in reset", 0, 0, green_o, 4'h0);
        check_color("blue_o in reset", 0, 0, blue_o, 4'h0);
        rst_n_i = 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            check_flag("wb_ack_o without a cycle", wb_ack_o, 1'b0);
            check_flag("hsync_o after reset", hsync_o, 1'b1);
            check_flag("vsync_o after reset", vsync_o, 1'b1);
        end

        // random font, only bits 7:0 are kept
        for (int i = 0; i < FONT_WORDS; i++) begin
            rng = xorshift32(rng);
            bus_write(wb_adr_t'(FONT_BASE + i), 4'hF, rng);
            font_model[i] = rng[7:0];
        end

        // random text with full sel, then read back
        for (int i = 0; i < TEXT_WORDS; i++) begin
            rng = xorshift32(rng);
            bus_write(wb_adr_t'(TEXT_BASE + i), 4'hF, rng);
            for (int l = 0; l < CHARS_PER_WORD; l++) begin
                text_model[CHARS_PER_WORD*i + l] = rng[8*l +: 7];
            end
        end
        for (int i = 0; i < TEXT_WORDS; i++) begin
            bus_read(wb_adr_t'(TEXT_BASE + i), got);
            check_word("text word", got, text_word(i));
        end

        // partial sel touches only the enabled characters
        for (int k = 0; k < 16; k++) begin
            rng = xorshift32(rng);
            w   = int'(rng[15:0]) % TEXT_WORDS;
            sel = rng[19:16];
            rng = xorshift32(rng);
            dat = rng;
            bus_write(wb_adr_t'(TEXT_BASE + w), sel, dat);
            for (int l = 0; l < CHARS_PER_WORD; l++) begin
                if (sel[l]) text_model[CHARS_PER_WORD*w + l] = dat[8*l +: 7];
            end
            bus_read(wb_adr_t'(TEXT_BASE + w), got);
            check_word("text word after partial write", got, text_word(w));
        end

        // colour registers as they came out of reset
        for (int i = 0; i < COLOR_WORDS; i++) begin
            bus_read(wb_adr_t'(COLOR_BASE + i), got);
            check_word("colour register after reset", got, wb_dat_t'(color_model[i]));
        end

        // colour round trip, then back to the reset colours
        rng = xorshift32(rng);
        write_colors(rng[23:0]);
        write_colors({3{COLOR_FG_RST, COLOR_BG_RST}});

        // font region and holes of the map read zero
        bus_read(wb_adr_t'('h000), got);
        check_word("font read", got, '0);
        bus_read(wb_adr_t'('h5A3), got);
        check_word("font read", got, '0);
        bus_read(wb_adr_t'(TEXT_BASE + TEXT_WORDS), got);
        check_word("unmapped read", got, '0);
        bus_read(wb_adr_t'(COLOR_BASE + COLOR_WORDS), got);
        check_word("unmapped read", got, '0);
        bus_read(wb_adr_t'('hFFF), got);
        check_word("unmapped read", got, '0);

        check_frame();  // reset colours

        // new colours land in the back porch, well before line 0
        rng = xorshift32(rng);
        write_colors(rng[23:0]);
        check_frame();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/vga_text_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_text_top
    import vga_text_pkg::*;
(
    input  wire logic       clk_i,    // pixel clock
    input  wire logic       rst_n_i,
    input  wire logic       wb_cyc_i,
    input  wire logic       wb_stb_i,
    input  wire logic       wb_we_i,
    input  wb_adr_t         wb_adr_i,
    input  wire logic [3:0] wb_sel_i,
    input  wb_dat_t         wb_dat_i,
    output wb_dat_t         wb_dat_o,
    output logic            wb_ack_o,
    output color_t          red_o,
    output color_t          green_o,
    output color_t          blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            de_o
);

    // --------------------------------------------------
    // interconnect
    // --------------------------------------------------
    logic       text_we;
    logic [3:0] text_be;
    text_addr_t text_bus_addr, text_vid_addr;
    text_word_t text_wdata, text_bus_rdata, text_vid_rdata;
    logic       font_we;
    font_addr_t font_waddr, font_raddr;
    glyph_row_t font_wdata, font_rdata;
    color_t     red_bg, red_fg, green_bg, green_fg, blue_bg, blue_fg;
    coord_t     hc, vc;
    logic       active, hsync_raw, vsync_raw;  // timing flags before the pipe delay

    // input side
    vga_bus_regs i_bus_regs (
        .clk_i, .rst_n_i,
        .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_sel_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
        .text_we_o(text_we), .text_be_o(text_be), .text_addr_o(text_bus_addr),
        .text_wdata_o(text_wdata), .text_rdata_i(text_bus_rdata),
        .font_we_o(font_we), .font_addr_o(font_waddr), .font_wdata_o(font_wdata),
        .red_bg_o(red_bg), .red_fg_o(red_fg), .green_bg_o(green_bg),
        .green_fg_o(green_fg), .blue_bg_o(blue_bg), .blue_fg_o(blue_fg)
    );

    vga_timing i_timing (
        .clk_i, .rst_n_i,
        .hc_o(hc), .vc_o(vc), .active_o(active), .hsync_o(hsync_raw), .vsync_o(vsync_raw)
    );

    vga_text_ram i_text_ram (
        .clk_i,
        .bus_we_i(text_we), .bus_be_i(text_be), .bus_addr_i(text_bus_addr),
        .bus_wdata_i(text_wdata), .bus_rdata_o(text_bus_rdata),
        .vid_addr_i(text_vid_addr), .vid_rdata_o(text_vid_rdata)
    );

    vga_font_ram i_font_ram (
        .clk_i,
        .we_i(font_we), .waddr_i(font_waddr), .wdata_i(font_wdata),
        .raddr_i(font_raddr), .rdata_o(font_rdata)
    );

    // output stage lives at the end of the pipe
    vga_pixel_pipe i_pixel_pipe (
        .clk_i, .rst_n_i,
        .hc_i(hc), .vc_i(vc), .active_i(active), .hsync_i(hsync_raw), .vsync_i(vsync_raw),
        .text_addr_o(text_vid_addr), .text_rdata_i(text_vid_rdata),
        .font_addr_o(font_raddr), .font_rdata_i(font_rdata),
        .red_bg_i(red_bg), .red_fg_i(red_fg), .green_bg_i(green_bg),
        .green_fg_i(green_fg), .blue_bg_i(blue_bg), .blue_fg_i(blue_fg),
        .red_o, .green_o, .blue_o, .hsync_o, .vsync_o, .de_o
    );

endmodule

`default_nettype wire

// File: verilog/vga_bus_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vga_bus_regs
    import vga_text_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    // wishbone classic slave
    input  wire logic       wb_cyc_i,
    input  wire logic       wb_stb_i,
    input  wire logic       wb_we_i,
    input  wb_adr_t         wb_adr_i,
    input  wire logic [3:0] wb_sel_i,
    input  wb_dat_t         wb_dat_i,
    output wb_dat_t         wb_dat_o,
    output logic            wb_ack_o,
    // text buffer port
    output logic            text_we_o,
    output logic [3:0]      text_be_o,
    output text_addr_t      text_addr_o,
    output text_word_t      text_wdata_o,
    input  text_word_t      text_rdata_i,
    // font write port
    output logic            font_we_o,
    output font_addr_t      font_addr_o,
    output glyph_row_t      font_wdata_o,
    // colour registers
    output color_t          red_bg_o,
    output color_t          red_fg_o,
    output color_t          green_bg_o,
    output color_t          green_fg_o,
    output color_t          blue_bg_o,
    output color_t          blue_fg_o
);

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    logic    cyc_start;  // first cycle of a bus access
    logic    in_font, in_text, in_color;
    wb_adr_t text_off, color_off;

    assign cyc_start = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign text_off  = wb_adr_i - wb_adr_t'(TEXT_BASE);
    assign color_off = wb_adr_i - wb_adr_t'(COLOR_BASE);
    assign in_font   = wb_adr_i < wb_adr_t'(FONT_BASE + FONT_WORDS);
    assign in_text   = (wb_adr_i >= wb_adr_t'(TEXT_BASE)) && (text_off < wb_adr_t'(TEXT_WORDS));
    assign in_color  = (wb_adr_i >= wb_adr_t'(COLOR_BASE)) && (color_off < wb_adr_t'(COLOR_WORDS));

    // memory strobes, high only in the start cycle so writes land as ack rises
    assign text_we_o    = cyc_start && wb_we_i && in_text;
    assign text_be_o    = wb_sel_i;  // one enable per character
    assign text_addr_o  = text_off[9:0];  // also the bus read index
    assign text_wdata_o = {wb_dat_i[30:24], wb_dat_i[22:16], wb_dat_i[14:8], wb_dat_i[6:0]};

    assign font_we_o    = cyc_start && wb_we_i && in_font;
    assign font_addr_o  = wb_adr_i[10:0];
    assign font_wdata_o = wb_dat_i[7:0];  // sel ignored

    // --------------------------------------------------
    // colour registers and ack
    // --------------------------------------------------
    color_t     color_q [COLOR_WORDS];
    logic       rd_text_q, rd_color_q;  // region latched at cycle start
    logic [2:0] rd_idx_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o   <= 1'b0;
            rd_text_q  <= 1'b0;
            rd_color_q <= 1'b0;
            for (int i = 0; i < COLOR_WORDS; i++) begin
                color_q[i] <= (i % 2 == 0) ? COLOR_BG_RST : COLOR_FG_RST;  // even = background
            end
        end else begin
            wb_ack_o <= cyc_start;  // no wait states
            if (cyc_start) begin
                rd_text_q  <= in_text;
                rd_color_q <= in_color;
                if (wb_we_i && in_color) begin
                    color_q[color_off[2:0]] <= wb_dat_i[3:0];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cyc_start) begin
            rd_idx_q <= color_off[2:0];
        end
    end

    assign red_bg_o   = color_q[0];
    assign red_fg_o   = color_q[1];
    assign green_bg_o = color_q[2];
    assign green_fg_o = color_q[3];
    assign blue_bg_o  = color_q[4];
    assign blue_fg_o  = color_q[5];

    // read mux, text codes come back with bit 7 of each byte at zero
    always_comb begin
        wb_dat_o = '0;  // font and unmapped read zero
        if (rd_text_q) begin
            wb_dat_o = {1'b0, text_rdata_i[27:21], 1'b0, text_rdata_i[20:14],
                        1'b0, text_rdata_i[13:7],  1'b0, text_rdata_i[6:0]};
        end else if (rd_color_q) begin
            wb_dat_o = wb_dat_t'(color_q[rd_idx_q]);
        end
    end

endmodule

`default_nettype wire

// File: video/vga_pixel_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module vga_pixel_pipe
    import vga_text_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    // raster from vga_timing
    input  coord_t    hc_i,
    input  coord_t    vc_i,
    input  wire logic active_i,
    input  wire logic hsync_i,
    input  wire logic vsync_i,
    // memory lookups, both answer one clock later
    output text_addr_t text_addr_o,
    input  text_word_t text_rdata_i,
    output font_addr_t font_addr_o,
    input  glyph_row_t font_rdata_i,
    // colour registers
    input  color_t    red_bg_i,
    input  color_t    red_fg_i,
    input  color_t    green_bg_i,
    input  color_t    green_fg_i,
    input  color_t    blue_bg_i,
    input  color_t    blue_fg_i,
    // video out
    output color_t    red_o,
    output color_t    green_o,
    output color_t    blue_o,
    output logic      hsync_o,
    output logic      vsync_o,
    output logic      de_o
);

    localparam int CODE_W = $bits(char_code_t);

    // --------------------------------------------------
    // stage 0: tile number and text fetch
    // --------------------------------------------------
    logic [11:0] tile;      // row*80 + col, up to 2399 when visible
    logic [1:0]  s0_lane;   // character within the text word
    logic [3:0]  s0_grow;   // glyph row
    logic [2:0]  s0_px;     // pixel within glyph
    logic        s0_act, s0_hs, s0_vs;

    always_comb begin
        tile = 12'(vc_i / GLYPH_H) * 12'(N_COLS) + 12'(hc_i / GLYPH_W);
    end

    assign text_addr_o = active_i ? tile[11:2] : '0;  // blanking reads word 0

    always_ff @(posedge clk_i) begin
        s0_lane <= tile[1:0];
        s0_grow <= vc_i[3:0];
        s0_px   <= hc_i[2:0];
    end

    // --------------------------------------------------
    // stage 1: pick the code, fetch the glyph row
    // --------------------------------------------------
    char_code_t code;
    logic [2:0] s1_px;
    logic       s1_act, s1_hs, s1_vs;

    assign code        = text_rdata_i[s0_lane*CODE_W +: CODE_W];
    assign font_addr_o = {code, s0_grow};

    always_ff @(posedge clk_i) begin
        s1_px <= s0_px;
    end

    // stage 2, bit 7 of the row is the leftmost pixel
    logic pix_on;
    assign pix_on = font_rdata_i[3'd7 - s1_px];

    // sync / enable delay line plus the registered colour stage
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            {s0_act, s1_act, de_o}     <= '0;
            {s0_hs, s1_hs, hsync_o}    <= '1;  // syncs idle high
            {s0_vs, s1_vs, vsync_o}    <= '1;
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
        end else begin
            s0_act  <= active_i;
            s0_hs   <= hsync_i;
            s0_vs   <= vsync_i;
            s1_act  <= s0_act;
            s1_hs   <= s0_hs;
            s1_vs   <= s0_vs;
            de_o    <= s1_act;
            hsync_o <= s1_hs;
            vsync_o <= s1_vs;
            red_o   <= !s1_act ? '0 : (pix_on ? red_fg_i   : red_bg_i);    // black in blanking
            green_o <= !s1_act ? '0 : (pix_on ? green_fg_i : green_bg_i);
            blue_o  <= !s1_act ? '0 : (pix_on ? blue_fg_i  : blue_bg_i);
        end
    end

endmodule

`default_nettype wire

// File: video/vga_font_ram.sv
`timescale 1ns/1ps
`default_nettype none

module vga_font_ram
    import vga_text_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic we_i,     // bus write strobe
    input  font_addr_t waddr_i,  // code*16 + row
    input  glyph_row_t wdata_i,
    input  font_addr_t raddr_i,  // from the pixel pipe
    output glyph_row_t rdata_o   // one clock after raddr_i
);

    glyph_row_t mem [FONT_WORDS];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire

// File: video/vga_text_ram.sv
`timescale 1ns/1ps
`default_nettype none

module vga_text_ram
    import vga_text_pkg::*;
(
    input  wire logic                      clk_i,
    // bus side, write with per-character enables
    input  wire logic                      bus_we_i,
    input  wire logic [CHARS_PER_WORD-1:0] bus_be_i,
    input  text_addr_t                     bus_addr_i,
    input  text_word_t                     bus_wdata_i,
    output text_word_t                     bus_rdata_o,
    // video side, read only
    input  text_addr_t                     vid_addr_i,
    output text_word_t                     vid_rdata_o
);

    localparam int CODE_W = $bits(char_code_t);

    text_word_t mem [TEXT_WORDS];  // one word per four tiles

    // --------------------------------------------------
    // write port, one lane per character
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (bus_we_i) begin
            for (int i = 0; i < CHARS_PER_WORD; i++) begin
                if (bus_be_i[i]) begin
                    mem[bus_addr_i][i*CODE_W +: CODE_W] <= bus_wdata_i[i*CODE_W +: CODE_W];
                end
            end
        end
    end

    // two independent registered reads
    always_ff @(posedge clk_i) begin
        bus_rdata_o <= mem[bus_addr_i];  // old data on a same-cycle write
        vid_rdata_o <= mem[vid_addr_i];  // pipe keeps the index in range
    end

endmodule

`default_nettype wire

// File: video/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import vga_text_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   rst_n_i,
    output coord_t      hc_o,      // horizontal position
    output coord_t      vc_o,      // vertical position
    output logic        active_o,  // (hc_o, vc_o) is visible
    output logic        hsync_o,   // active low
    output logic        vsync_o    // active low
);

    // --------------------------------------------------
    // sync window bounds
    // --------------------------------------------------
    localparam int HS_START = H_ACTIVE + H_FRONT;  // 656
    localparam int HS_END   = HS_START + H_SYNC;   // 752, exclusive
    localparam int VS_START = V_ACTIVE + V_FRONT;  // 490
    localparam int VS_END   = VS_START + V_SYNC;   // 492, exclusive

    coord_t hc_nxt;
    coord_t vc_nxt;

    // next raster position, flags are derived from it so they
    // line up with the registered counters
    always_comb begin
        hc_nxt = hc_o + 10'd1;
        vc_nxt = vc_o;
        if (hc_o == coord_t'(H_TOTAL - 1)) begin
            hc_nxt = '0;  // end of line
            if (vc_o == coord_t'(V_TOTAL - 1)) begin
                vc_nxt = '0;  // end of frame
            end else begin
                vc_nxt = vc_o + 10'd1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hc_o     <= '0;
            vc_o     <= '0;
            active_o <= 1'b1;  // (0,0) is visible
            hsync_o  <= 1'b1;
            vsync_o  <= 1'b1;
        end else begin
            hc_o     <= hc_nxt;
            vc_o     <= vc_nxt;
            active_o <= (hc_nxt < coord_t'(H_ACTIVE)) && (vc_nxt < coord_t'(V_ACTIVE));
            hsync_o  <= !((hc_nxt >= coord_t'(HS_START)) && (hc_nxt < coord_t'(HS_END)));
            vsync_o  <= !((vc_nxt >= coord_t'(VS_START)) && (vc_nxt < coord_t'(VS_END)));
        end
    end

endmodule

`default_nettype wire

// File: common/vga_text_pkg.sv
`default_nettype none

package vga_text_pkg;

    // --------------------------------------------------
    // video timing, 640x480 at the pixel clock
    // --------------------------------------------------
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    // --------------------------------------------------
    // tile geometry
    // --------------------------------------------------
    localparam int GLYPH_W        = 8;
    localparam int GLYPH_H        = 16;
    localparam int N_COLS         = H_ACTIVE / GLYPH_W;               // 80
    localparam int N_ROWS         = V_ACTIVE / GLYPH_H;               // 30
    localparam int CHARS_PER_WORD = 4;
    localparam int TEXT_WORDS     = N_COLS * N_ROWS / CHARS_PER_WORD; // 600

    // word address map of the bus
    localparam int FONT_BASE   = 'h000;
    localparam int FONT_WORDS  = 2048;  // 128 codes x 16 rows
    localparam int TEXT_BASE   = 'h800;
    localparam int COLOR_BASE  = 'hC00;
    localparam int COLOR_WORDS = 6;     // r bg, r fg, g bg, g fg, b bg, b fg

    localparam logic [3:0] COLOR_BG_RST = 4'h0;  // black background
    localparam logic [3:0] COLOR_FG_RST = 4'hF;  // white glyphs

    typedef logic [9:0]  coord_t;      // raster counter / position
    typedef logic [3:0]  color_t;      // one colour channel
    typedef logic [6:0]  char_code_t;
    typedef logic [7:0]  glyph_row_t;  // bit 7 is the leftmost pixel
    typedef logic [9:0]  text_addr_t;
    typedef logic [27:0] text_word_t;  // four packed codes, lane 0 in 6:0
    typedef logic [10:0] font_addr_t;  // {code, glyph row}
    typedef logic [11:0] wb_adr_t;
    typedef logic [31:0] wb_dat_t;

endpackage

`default_nettype wire
